//--- verilog/life_pkg.sv
/* life_pkg
   frame sizing, pipeline latencies and row types for the linear life engine
*/
package life_pkg;

	//////////////////////////////////////////////////
	// frame geometry
	//////////////////////////////////////////////////

	localparam int row_width = 16; // cells per row, horizontal wrap point
	localparam int row_depth = 16; // rows held in the ram
	localparam int addr_bits = $clog2(row_depth);

	localparam int gens = 2; // generation stages per pass

	//////////////////////////////////////////////////
	// pipeline latencies
	//////////////////////////////////////////////////

	// address edge to valid ram q
	localparam int ram_read_lat = 1;

	// sh delay so the chain samples q on the edge after it goes valid
	localparam int sh_delay = ram_read_lat + 1;

	// steps from a row entering a window to its new state being sampled
	// one step into the window middle, one into the tally, one downstream
	localparam int stage_lag = 3;

	//////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////

	typedef logic [row_width-1:0] row_t; // one frame row
	typedef logic [addr_bits-1:0] addr_t; // row address
	typedef logic [1:0] tally_t; // vertical sum of three cells, 0..3

endpackage

//--- verilog/cell_ram.sv
/* cell_ram
   two-port row memory, one frame row per word, registered read path
*/
`timescale 1ns/1ps

module cell_ram (
	input  logic            clk,
	input  life_pkg::row_t  wdata, // init row or writeback row
	input  life_pkg::addr_t raddr,
	input  life_pkg::addr_t waddr,
	input  logic            we,
	output life_pkg::row_t  q // valid one edge after the address edge
);

	// one word per row
	life_pkg::row_t mem [0:life_pkg::row_depth-1];

	life_pkg::row_t rd_row; // array read, taken at the address edge

	//////////////////////////////////////////////////
	// write port
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata; // lands at this edge
		end
	end

	//////////////////////////////////////////////////
	// read port
	//////////////////////////////////////////////////

	// address sampled at edge k picks the word as it stood before k
	// so a same-edge write to that row is not seen (old data mode)
	always_ff @(posedge clk) begin
		rd_row <= mem[raddr];
	end

	// output register, q settles after edge k+1
	always_ff @(posedge clk) begin
		q <= rd_row;
	end

endmodule

//--- verilog/life_gen_stage.sv
/* life_gen_stage
   one life generation over a stream of rows
   three row window, registered column tally, wrapped row sum, life rule
*/
`timescale 1ns/1ps

module life_gen_stage (
	input  logic           clk,
	input  logic           step, // chain advance, everything here holds without it
	input  life_pkg::row_t row_in, // next row of the previous generation
	output life_pkg::row_t row_out // new state of the tally center row
);
	import life_pkg::*;

	// win[0] newest, win[2] oldest
	row_t win [0:2];

	// per column sum of the three window cells, taken on step
	tally_t [row_width-1:0] tally_q;

	// full nine cell count per column, 0..9
	logic [3:0] sum9 [0:row_width-1];

	//////////////////////////////////////////////////
	// row window
	//////////////////////////////////////////////////

	// shift in one row per step
	// a row sits in win[0], then win[1], then win[2]
	always_ff @(posedge clk) begin
		if (step) begin
			win[2] <= win[1];
			win[1] <= win[0];
			win[0] <= row_in; // newest row
		end
	end

	//////////////////////////////////////////////////
	// vertical tally
	//////////////////////////////////////////////////

	// taken on the same step that moves win[1] into win[2]
	// so after the step win[2] is the center of tally_q
	always_ff @(posedge clk) begin
		if (step) begin
			for (int c = 0; c < row_width; c++) begin
				tally_q[c] <= {1'b0, win[2][c]}
					+ {1'b0, win[1][c]}
					+ {1'b0, win[0][c]};
			end
		end
	end

	//////////////////////////////////////////////////
	// horizontal sum
	//////////////////////////////////////////////////

	// own column plus both neighbours
	// column 0 and the last column are neighbours of each other
	always_comb begin
		for (int c = 0; c < row_width; c++) begin
			sum9[c] = {2'b00, tally_q[(c + row_width - 1) % row_width]} // lower neighbour
				+ {2'b00, tally_q[c]}
				+ {2'b00, tally_q[(c + 1) % row_width]}; // upper neighbour
		end
	end

	//////////////////////////////////////////////////
	// life rule
	//////////////////////////////////////////////////

	// sum9 includes the cell itself
	// 3 means born or survives with two neighbours
	// 4 means survives with three neighbours, only if already alive
	// anything else is dead next generation
	always_comb begin
		for (int c = 0; c < row_width; c++) begin
			row_out[c] = (sum9[c] == 4'd3) || ((sum9[c] == 4'd4) && win[2][c]);
		end
	end

	// row_out follows stage state only
	// it is sampled by the next stage or the writeback reg on the next step

endmodule

//--- verilog/row_readout.sv
/* row_readout
   display read path, latches one ram row onto dout two edges after ld
*/
`timescale 1ns/1ps

module row_readout (
	input  logic           clk,
	input  logic           rst,
	input  logic           ld, // load strobe, raddr held at the same edge
	input  life_pkg::row_t q, // ram read data
	output life_pkg::row_t dout // display row, holds between loads
);
	import life_pkg::*;

	// same latency as the shift path, ram address edge to q sample
	logic [sh_delay-1:0] ld_dly;

	always_ff @(posedge clk) begin
		if (rst) begin
			ld_dly <= '0;
			dout   <= '0;
		end else begin
			// two loads may be in flight back to back
			ld_dly <= {ld_dly[sh_delay-2:0], ld};
			if (ld_dly[sh_delay-1]) begin
				dout <= q; // row read at the ld edge
			end
		end
	end

endmodule

//--- verilog/life_engine.sv
/* life_engine
   linear life engine top, row ram feeding a chain of generation stages
   with writeback of the last generation and a display read path
*/
`timescale 1ns/1ps

module life_engine (
	input  logic            clk,
	input  logic            rst,
	// memory control
	input  life_pkg::addr_t raddr, // shift reads and display reads
	input  life_pkg::addr_t waddr, // init writes and writebacks
	input  logic            we,
	// chain shift
	input  logic            sh,
	// display port
	input  logic            ld,
	output life_pkg::row_t  dout,
	// init port
	input  logic            init,
	input  life_pkg::row_t  init_data
);
	import life_pkg::*;

	// chain[0] is ram q, chain[g+1] is the output of stage g
	row_t chain [0:gens];

	row_t ram_wdata;
	row_t wb_row; // last generation, written back on we

	logic [sh_delay-1:0] sh_dly;
	logic step; // global enable for the stage chain

	//////////////////////////////////////////////////
	// row memory
	//////////////////////////////////////////////////

	// init wins the write port, otherwise the new generation goes back
	assign ram_wdata = init ? init_data : wb_row;

	cell_ram ram_i (
		.clk  (clk),
		.wdata(ram_wdata),
		.raddr(raddr),
		.waddr(waddr),
		.we   (we),
		.q    (chain[0])
	);

	// display latch on the same read port
	row_readout readout_i (
		.clk (clk),
		.rst (rst),
		.ld  (ld),
		.q   (chain[0]),
		.dout(dout)
	);

	//////////////////////////////////////////////////
	// shift enable
	//////////////////////////////////////////////////

	// sh at edge k steps the chain at edge k+2, when q holds that read
	always_ff @(posedge clk) begin
		if (rst) begin
			sh_dly <= '0;
		end else begin
			sh_dly <= {sh_dly[sh_delay-2:0], sh};
		end
	end

	assign step = sh_dly[sh_delay-1];

	//////////////////////////////////////////////////
	// generation chain
	//////////////////////////////////////////////////

	genvar g;
	generate
		for (g = 0; g < gens; g++) begin : gen_stage
			life_gen_stage stage_i (
				.clk    (clk),
				.step   (step),
				.row_in (chain[g]), // ram row or previous generation
				.row_out(chain[g+1])
			);
		end
	endgenerate

	// last stage output, held until the next step
	// for a row read at edge k this holds its result after step k+2+3*gens
	always_ff @(posedge clk) begin
		if (step) begin
			wb_row <= chain[gens];
		end
	end

endmodule

//--- tb/life_tb_tasks.svh
/* life engine testbench tasks
   ram writes, pass sequencing, display reads and row compares
*/
`ifndef LIFE_TB_TASKS_SVH
`define LIFE_TB_TASKS_SVH

//////////////////////////////////////////////////
// drive
//////////////////////////////////////////////////

// one init write, we stays high until the next drive
task automatic write_row(input addr_t addr, input row_t data);
	@(posedge clk);
	#drive_dly;
	we        = 1'b1;
	init      = 1'b1;
	waddr     = addr;
	init_data = data;
endtask

task automatic idle_cycle();
	@(posedge clk);
	#drive_dly;
	we   = 1'b0;
	init = 1'b0;
	sh   = 1'b0;
	ld   = 1'b0;
endtask

// one pass over an 8 row torus, two rows of margin each side
// read index a holds row (a - gens) mod 8, centers a = gens .. gens+7 are valid
// result of read a is in the writeback reg after sh index a + stage_lag*gens
task automatic run_pass(input int src_base, input int dst_base,
		input int gap_idx, input int gap_cycles);
	int act_cyc [0:pass_acts-1]; // drive cycle of each sh pulse
	int a;
	int j;
	int t;
	int total;
	t = 0;
	for (a = 0; a < pass_acts; a++) begin
		if (a == gap_idx) begin
			t = t + gap_cycles; // sh low here, chain frozen
		end
		act_cyc[a] = t;
		t++;
	end
	total = act_cyc[pass_acts-1] + sh_delay + 2;
	a = 0;
	for (t = 0; t < total; t++) begin
		@(posedge clk);
		#drive_dly;
		sh = 1'b0;
		we = 1'b0;
		if (a < pass_acts && act_cyc[a] == t) begin
			sh    = 1'b1;
			raddr = addr_t'(src_base + (a + frame_rows - gens) % frame_rows);
			a++;
		end
		for (j = gens; j < gens + frame_rows; j++) begin
			// write edge trails its sh edge by the delay line plus the wb reg
			if (act_cyc[j + stage_lag * gens] + sh_delay + 1 == t) begin
				we    = 1'b1;
				waddr = addr_t'(dst_base + j - gens);
			end
		end
	end
	idle_cycle();
endtask

// back to back ld, dout sampled 3 drive cycles after each ld
task automatic read_rows(input int base);
	int c;
	for (c = 0; c < frame_rows + 3; c++) begin
		@(posedge clk);
		#drive_dly;
		if (c >= 3) begin
			got_rows[c-3] = dout; // stable since the last edge
		end
		ld    = (c < frame_rows);
		raddr = addr_t'(base + c);
	end
endtask

//////////////////////////////////////////////////
// compare
//////////////////////////////////////////////////

task automatic check_row(input string test, input row_t exp, input row_t act);
	checks++;
	if (act !== exp) begin
		$display("Fail %s expected %h actual %h", test, exp, act);
		$display(">>> FAIL");
		$fatal(1, "row mismatch");
	end
endtask

task automatic check_zero(input string test, input row_t act);
	checks++;
	if (act !== '0) begin
		$display("Fail %s expected %h actual %h", test, row_t'(0), act);
		$display(">>> FAIL");
		$fatal(1, "row not cleared");
	end
endtask

`endif

//--- tb/life_engine_tb.sv
/* life_engine testbench
   file driven checks of reset, init display, passes, sh gaps and a random frame
*/
`timescale 1ns/1ps

module life_engine_tb;
	import life_pkg::*;

	localparam int clk_period = 100;
	localparam int drive_dly  = 10; // after the rising edge
	localparam int frame_rows = row_depth / 2; // each ram half is one torus
	localparam int pass_acts  = frame_rows + gens * (stage_lag + 1); // sh pulses per pass
	localparam int max_recs   = 16;

	logic  clk;
	logic  rst;
	addr_t raddr;
	addr_t waddr;
	logic  we;
	logic  sh;
	logic  ld;
	logic  init;
	row_t  init_data;
	row_t  dout;

	// records from the data file
	string rec_tag  [0:max_recs-1];
	string rec_name [0:max_recs-1];
	int    rec_arg0 [0:max_recs-1];
	int    rec_arg1 [0:max_recs-1];
	row_t  rec_rows [0:max_recs-1][0:frame_rows-1];
	int    n_recs;
	logic  data_ready;

	row_t got_rows   [0:frame_rows-1]; // display readback
	row_t model_rows [0:frame_rows-1]; // reference frame for the random test

	int checks;
	int seed;
	int gap_at; // -1 means no sh gap
	int gap_len;
	int src_half; // half that holds the current frame

	life_engine dut_i (
		.clk      (clk),
		.rst      (rst),
		.raddr    (raddr),
		.waddr    (waddr),
		.we       (we),
		.sh       (sh),
		.ld       (ld),
		.dout     (dout),
		.init     (init),
		.init_data(init_data)
	);

	`include "life_tb_tasks.svh"

	//////////////////////////////////////////////////
	// clock and watchdog
	//////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever begin
			#(clk_period / 2) clk = ~clk;
		end
	end

	initial begin
		real limit_ns;
		wait (data_ready === 1'b1);
		// cycle budget per record
		limit_ns = real'(n_recs) * real'(row_depth + stage_lag * gens + 12) * clk_period;
		#(limit_ns);
		$display("timeout, the test sequence did not finish in time");
		$display(">>> FAIL");
		$fatal(1, "watchdog");
	end

	//////////////////////////////////////////////////
	// data file and reference model
	//////////////////////////////////////////////////

	task automatic load_testdata();
		int    fd;
		int    rc;
		int    rows_left;
		int    a0;
		int    a1;
		string line;
		string tag;
		string name;
		row_t  rv;
		rows_left = 0;
		n_recs    = 0;
		fd = $fopen("tb/life_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open the test data file tb/life_testdata.txt");
			$display(">>> FAIL");
			$fatal(1, "no test data");
		end
		while (!$feof(fd)) begin
			line = "";
			rc = $fgets(line, fd);
			if (rc > 1 && line[0] != "#") begin // skip blanks and comments
				if (rows_left > 0) begin
					rc = $sscanf(line, "%h", rv);
					if (rc != 1) begin
						$display("bad row line in the test data: %s", line);
						$display(">>> FAIL");
						$fatal(1, "bad row");
					end
					rec_rows[n_recs-1][frame_rows-rows_left] = rv;
					rows_left--;
				end else begin
					a0 = 0;
					a1 = 0;
					rc = $sscanf(line, "%s %s %d %d", tag, name, a0, a1);
					if (n_recs >= max_recs || !(tag == "init" || tag == "expect"
							|| tag == "hold" || tag == "rand")) begin
						$display("unknown or extra record in the test data: %s", line);
						$display(">>> FAIL");
						$fatal(1, "bad record");
					end
					rec_tag[n_recs]  = tag;
					rec_name[n_recs] = name;
					rec_arg0[n_recs] = a0;
					rec_arg1[n_recs] = a1;
					n_recs++;
					if (tag == "init" || tag == "expect") begin
						rows_left = frame_rows; // frame follows
					end
				end
			end
		end
		$fclose(fd);
		if (rows_left != 0) begin
			$display("test data ends in the middle of a frame");
			$display(">>> FAIL");
			$fatal(1, "short frame");
		end
	endtask

	// one generation of model_rows counted by neighbours on the torus
	task automatic model_generation();
		row_t nxt [0:frame_rows-1];
		int   r;
		int   c;
		int   dr;
		int   dc;
		int   n;
		for (r = 0; r < frame_rows; r++) begin
			for (c = 0; c < row_width; c++) begin
				n = 0;
				for (dr = -1; dr <= 1; dr++) begin
					for (dc = -1; dc <= 1; dc++) begin
						if (dr != 0 || dc != 0) begin
							n = n + model_rows[(r + dr + frame_rows) % frame_rows]
								[(c + dc + row_width) % row_width];
						end
					end
				end
				nxt[r][c] = (n == 3) || (n == 2 && model_rows[r][c]); // born or survives
			end
		end
		for (r = 0; r < frame_rows; r++) begin
			model_rows[r] = nxt[r];
		end
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial begin
		int r;
		int p;
		int i;
		rst        = 1'b1;
		raddr      = '0;
		waddr      = '0;
		we         = 1'b0;
		sh         = 1'b0;
		ld         = 1'b0;
		init       = 1'b0;
		init_data  = '0;
		checks     = 0;
		seed       = 32'h21ea;
		gap_at     = -1;
		gap_len    = 0;
		src_half   = 0;
		data_ready = 1'b0;
		load_testdata();
		data_ready = 1'b1;

		repeat (2) @(posedge clk);
		#drive_dly;
		rst = 1'b0;
		check_zero("reset_dout", dout); // before any ld

		for (i = 0; i < n_recs; i++) begin
			if (rec_tag[i] == "init") begin
				for (r = 0; r < frame_rows; r++) begin
					write_row(addr_t'(r), rec_rows[i][r]);
				end
				idle_cycle();
				src_half = 0;
				read_rows(0);
				for (r = 0; r < frame_rows; r++) begin
					check_row($sformatf("%s row %0d", rec_name[i], r), rec_rows[i][r], got_rows[r]);
				end
			end else if (rec_tag[i] == "hold") begin
				gap_at  = rec_arg0[i];
				gap_len = rec_arg1[i];
			end else if (rec_tag[i] == "expect") begin
				for (p = 0; p < rec_arg0[i]; p++) begin
					run_pass(src_half * frame_rows, (1 - src_half) * frame_rows, gap_at, gap_len);
					src_half = 1 - src_half; // result lands in the other half
				end
				gap_at  = -1;
				gap_len = 0;
				read_rows(src_half * frame_rows);
				for (r = 0; r < frame_rows; r++) begin
					check_row($sformatf("%s row %0d", rec_name[i], r), rec_rows[i][r], got_rows[r]);
				end
			end else begin
				for (r = 0; r < frame_rows; r++) begin
					model_rows[r] = row_t'($random(seed));
					write_row(addr_t'(r), model_rows[r]);
				end
				idle_cycle();
				for (p = 0; p < gens; p++) begin
					model_generation();
				end
				run_pass(0, frame_rows, -1, 0);
				src_half = 1;
				read_rows(frame_rows);
				for (r = 0; r < frame_rows; r++) begin
					check_row($sformatf("%s row %0d", rec_name[i], r), model_rows[r], got_rows[r]);
				end
			end
		end

		// more than the reset compare alone
		if (checks > 1) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display("no frame from the test data was checked");
			$display(">>> FAIL");
			$fatal(1, "empty test");
		end
	end

endmodule

//--- vlog.f
+incdir+tb
verilog/life_pkg.sv
verilog/cell_ram.sv
verilog/life_gen_stage.sv
verilog/row_readout.sv
verilog/life_engine.sv
tb/life_engine_tb.sv

//--- tb/life_testdata.txt
# tag name [arg0 arg1], init and expect are followed by 8 hex rows, row 0 first, bit 0 = column 0
# expect arg0 = passes of two generations, hold arg0 = sh index of the gap, arg1 = gap cycles
init blinker_block
0200
0200
0000
0000
3000
3000
0000
0200
expect blinker_block_pass 1
0200
0200
0000
0000
3000
3000
0000
0200
init glider_wrap
0000
8000
0001
C001
0000
0000
0000
0000
expect glider_wrap_two_pass 2
0000
0000
0001
0002
8003
0000
0000
0000
hold glider_gap 9 3
expect glider_gap_two_pass 2
0000
0000
0000
0002
0004
0007
0000
0000
rand random_frame
